// ==== src.f ====
design/bus_pkg.sv
design/cache_pkg.sv
design/dcache_ram.sv
design/bus_wbuf.sv
design/dcache_ctrl.sv
design/bus_arbiter.sv
design/axil_master.sv
design/mem_subsys_top.sv
sim/axil_mem_model.sv
sim/mem_subsys_props.sv
sim/tb_top.sv

// ==== sim/tb_top.sv ====
// Memory subsystem testbench
// Table-driven CPU and I/O traffic checked against a reference model of cache and memory

`timescale 1ns/1ps

module tb_top;
	import bus_pkg::*;
	import cache_pkg::*;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_FLUSH
	} op_t;

	typedef struct packed {
		logic io_port;
		op_t op;
		logic cacheable;
		// Runs together with the next row, an I/O row
		logic concurrent;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [31:0] exp_data;
		logic [1:0] hit_delta;
		logic [1:0] miss_delta;
	} step_t;

	logic clock;
	logic reset;
	logic cpu_request;
	logic cpu_rw;
	logic cpu_flush;
	logic cpu_cacheable;
	logic [31:0] cpu_address;
	logic [31:0] cpu_wdata;
	logic cpu_ready;
	logic [31:0] cpu_rdata;
	logic io_request;
	logic io_rw;
	logic [31:0] io_address;
	logic [31:0] io_wdata;
	logic io_ready;
	logic [31:0] io_rdata;
	logic [31:0] hit_count;
	logic [31:0] miss_count;
	axil_aw_t aw;
	axil_w_t w;
	axil_b_t b;
	axil_ar_t ar;
	axil_r_t r;
	logic awready;
	logic wready;
	logic arready;
	logic bready;
	logic rready;

	step_t rows[$];
	int errors;
	int checks;
	int cycles;
	int cycle_limit;
	logic [31:0] exp_hits;
	logic [31:0] exp_misses;

	// Reference model state
	logic [31:0] ref_mem [logic [31:0]];
	cache_entry_t lines [CACHE_LINES];

	mem_subsys_top dut0 (
		.i_clock(clock),
		.i_reset(reset),
		.i_cpu_request(cpu_request),
		.i_cpu_rw(cpu_rw),
		.i_cpu_flush(cpu_flush),
		.i_cpu_cacheable(cpu_cacheable),
		.i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata),
		.o_cpu_ready(cpu_ready),
		.o_cpu_rdata(cpu_rdata),
		.i_io_request(io_request),
		.i_io_rw(io_rw),
		.i_io_address(io_address),
		.i_io_wdata(io_wdata),
		.o_io_ready(io_ready),
		.o_io_rdata(io_rdata),
		.o_hit_count(hit_count),
		.o_miss_count(miss_count),
		.o_aw(aw),
		.i_awready(awready),
		.o_w(w),
		.i_wready(wready),
		.i_b(b),
		.o_bready(bready),
		.o_ar(ar),
		.i_arready(arready),
		.i_r(r),
		.o_rready(rready)
	);

	axil_mem_model mem0 (
		.i_clock(clock),
		.i_reset(reset),
		.i_aw(aw),
		.o_awready(awready),
		.i_w(w),
		.o_wready(wready),
		.o_b(b),
		.i_bready(bready),
		.i_ar(ar),
		.o_arready(arready),
		.o_r(r),
		.i_rready(rready)
	);

	always #2 clock = ~clock;

	// Watchdog
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ====================
	// Reference model
	// ====================

	function automatic logic [31:0] memory_word(input logic [31:0] address);
		if (ref_mem.exists(address))
			return ref_mem[address];
		return address ^ 32'hc0de_0000;
	endfunction

	function automatic void flush_lines();
		for (int n = 0; n < CACHE_LINES; n++) begin
			if (lines[n].valid && lines[n].dirty) begin
				ref_mem[{lines[n].address, 2'b00}] = lines[n].data;
				lines[n].dirty = 1'b0;
			end
		end
	endfunction

	// Returns what the CPU reads, updates cache and memory state
	function automatic logic [31:0] cpu_outcome(input step_t s);
		int idx;
		idx = s.address[INDEX_BITS+1:2];
		if (s.op == OP_FLUSH) begin
			flush_lines();
			return 32'h0;
		end
		if (!s.cacheable) begin
			if (s.op == OP_WRITE)
				ref_mem[s.address] = s.wdata;
			return memory_word(s.address);
		end
		// Miss, dirty victim goes back to memory first
		if (!(lines[idx].valid && lines[idx].address == s.address[31:2])) begin
			if (lines[idx].valid && lines[idx].dirty)
				ref_mem[{lines[idx].address, 2'b00}] = lines[idx].data;
			lines[idx] = '{data: memory_word(s.address), address: s.address[31:2],
				dirty: 1'b0, valid: 1'b1};
		end
		if (s.op == OP_WRITE) begin
			lines[idx].data = s.wdata;
			lines[idx].dirty = 1'b1;
		end
		return lines[idx].data;
	endfunction

	function automatic logic [31:0] io_outcome(input step_t s);
		if (s.op == OP_WRITE)
			ref_mem[s.address] = s.wdata;
		return memory_word(s.address);
	endfunction

	// ====================
	// Stimulus
	// ====================

	task automatic add_row(input logic io_port, input op_t op, input logic cacheable,
			input logic concurrent, input logic [31:0] address, input logic [31:0] wdata,
			input logic [31:0] exp_data, input logic [1:0] hit_delta,
			input logic [1:0] miss_delta);
		step_t s;
		s = '{io_port, op, cacheable, concurrent, address, wdata, exp_data, hit_delta,
			miss_delta};
		rows.push_back(s);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("[FAIL] t=%0t ns %s expected %h actual %h", $time, name, expected, actual);
	endtask

	task automatic run_step(input step_t cpu_step, input logic cpu_on, input step_t io_step,
			input logic io_on);
		logic [31:0] cpu_want;
		logic [31:0] io_want;
		logic cpu_busy;
		logic io_busy;
		cpu_want = 32'h0;
		io_want = 32'h0;
		cpu_busy = cpu_on;
		io_busy = io_on;
		if (cpu_on) begin
			cpu_want = cpu_outcome(cpu_step);
			exp_hits = exp_hits + cpu_step.hit_delta;
			exp_misses = exp_misses + cpu_step.miss_delta;
			if (cpu_step.op == OP_READ && cpu_want !== cpu_step.exp_data) begin
				errors++;
				$display("Table row for CPU address %h disagrees with the reference model",
					cpu_step.address);
			end
		end
		if (io_on) begin
			io_want = io_outcome(io_step);
			if (io_step.op == OP_READ && io_want !== io_step.exp_data) begin
				errors++;
				$display("Table row for I/O address %h disagrees with the reference model",
					io_step.address);
			end
		end

		@(negedge clock);
		if (cpu_on) begin
			cpu_request = 1'b1;
			cpu_rw = (cpu_step.op == OP_WRITE);
			cpu_flush = (cpu_step.op == OP_FLUSH);
			cpu_cacheable = cpu_step.cacheable;
			cpu_address = cpu_step.address;
			cpu_wdata = cpu_step.wdata;
		end
		if (io_on) begin
			io_request = 1'b1;
			io_rw = (io_step.op == OP_WRITE);
			io_address = io_step.address;
			io_wdata = io_step.wdata;
		end

		// Ready pulses are caught on the falling edge
		while (cpu_busy || io_busy) begin
			@(negedge clock);
			if (cpu_busy && cpu_ready) begin
				cpu_busy = 1'b0;
				cpu_request = 1'b0;
				if (cpu_step.op == OP_READ) begin
					checks++;
					if (cpu_rdata !== cpu_want)
						report_mismatch("o_cpu_rdata", cpu_want, cpu_rdata);
				end
			end
			if (io_busy && io_ready) begin
				io_busy = 1'b0;
				io_request = 1'b0;
				if (io_step.op == OP_READ) begin
					checks++;
					if (io_rdata !== io_want)
						report_mismatch("o_io_rdata", io_want, io_rdata);
				end
			end
		end

		checks += 2;
		if (hit_count !== exp_hits)
			report_mismatch("o_hit_count", exp_hits, hit_count);
		if (miss_count !== exp_misses)
			report_mismatch("o_miss_count", exp_misses, miss_count);
	endtask

	initial begin
		int i;
		clock = 1'b0;
		reset = 1'b1;
		cpu_request = 1'b0;
		cpu_rw = 1'b0;
		cpu_flush = 1'b0;
		cpu_cacheable = 1'b0;
		cpu_address = 32'h0;
		cpu_wdata = 32'h0;
		io_request = 1'b0;
		io_rw = 1'b0;
		io_address = 32'h0;
		io_wdata = 32'h0;
		errors = 0;
		checks = 0;
		cycles = 0;
		exp_hits = 32'h0;
		exp_misses = 32'h0;
		for (int n = 0; n < CACHE_LINES; n++)
			lines[n] = CLEAR_ENTRY;

		// io, op, cacheable, concurrent, address, wdata, read data, hits, misses
		add_row(1'b0, OP_READ, 1'b1, 1'b0, 32'h0000_0100, 32'h0, 32'hc0de_0100, 2'd0, 2'd1);
		add_row(1'b0, OP_READ, 1'b1, 1'b0, 32'h0000_0100, 32'h0, 32'hc0de_0100, 2'd1, 2'd0);
		// Dirty line hides the write from I/O
		add_row(1'b0, OP_WRITE, 1'b1, 1'b0, 32'h0000_0104, 32'h1111_0001, 32'h0, 2'd0, 2'd1);
		add_row(1'b0, OP_READ, 1'b1, 1'b0, 32'h0000_0104, 32'h0, 32'h1111_0001, 2'd1, 2'd0);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0104, 32'h0, 32'hc0de_0104, 2'd0, 2'd0);
		// Same index evicts the dirty line
		add_row(1'b0, OP_READ, 1'b1, 1'b0, 32'h0000_0204, 32'h0, 32'hc0de_0204, 2'd0, 2'd1);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0104, 32'h0, 32'h1111_0001, 2'd0, 2'd0);
		// Flush
		add_row(1'b0, OP_WRITE, 1'b1, 1'b0, 32'h0000_0108, 32'h2222_0002, 32'h0, 2'd0, 2'd1);
		add_row(1'b0, OP_WRITE, 1'b1, 1'b0, 32'h0000_010c, 32'h3333_0003, 32'h0, 2'd0, 2'd1);
		add_row(1'b0, OP_WRITE, 1'b1, 1'b0, 32'h0000_0100, 32'h4444_0004, 32'h0, 2'd1, 2'd0);
		add_row(1'b0, OP_FLUSH, 1'b1, 1'b0, 32'h0000_0000, 32'h0, 32'h0, 2'd0, 2'd0);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0108, 32'h0, 32'h2222_0002, 2'd0, 2'd0);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_010c, 32'h0, 32'h3333_0003, 2'd0, 2'd0);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0100, 32'h0, 32'h4444_0004, 2'd0, 2'd0);
		add_row(1'b0, OP_READ, 1'b1, 1'b0, 32'h0000_0108, 32'h0, 32'h2222_0002, 2'd1, 2'd0);
		// Uncached CPU accesses
		add_row(1'b0, OP_WRITE, 1'b0, 1'b0, 32'h0000_0300, 32'h5555_0005, 32'h0, 2'd0, 2'd0);
		add_row(1'b0, OP_READ, 1'b0, 1'b0, 32'h0000_0300, 32'h0, 32'h5555_0005, 2'd0, 2'd0);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0300, 32'h0, 32'h5555_0005, 2'd0, 2'd0);
		add_row(1'b0, OP_READ, 1'b0, 1'b0, 32'h0000_0304, 32'h0, 32'hc0de_0304, 2'd0, 2'd0);
		// Concurrent pairs
		add_row(1'b0, OP_READ, 1'b1, 1'b1, 32'h0000_0410, 32'h0, 32'hc0de_0410, 2'd0, 2'd1);
		add_row(1'b1, OP_WRITE, 1'b0, 1'b0, 32'h0000_0500, 32'h6666_0006, 32'h0, 2'd0, 2'd0);
		add_row(1'b0, OP_WRITE, 1'b1, 1'b1, 32'h0000_0414, 32'h7777_0007, 32'h0, 2'd0, 2'd1);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0500, 32'h0, 32'h6666_0006, 2'd0, 2'd0);
		add_row(1'b0, OP_READ, 1'b1, 1'b1, 32'h0000_0510, 32'h0, 32'hc0de_0510, 2'd0, 2'd1);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0600, 32'h0, 32'hc0de_0600, 2'd0, 2'd0);
		add_row(1'b0, OP_READ, 1'b1, 1'b1, 32'h0000_0614, 32'h0, 32'hc0de_0614, 2'd0, 2'd1);
		add_row(1'b1, OP_WRITE, 1'b0, 1'b0, 32'h0000_0700, 32'h8888_0008, 32'h0, 2'd0, 2'd0);
		add_row(1'b1, OP_READ, 1'b0, 1'b0, 32'h0000_0414, 32'h0, 32'h7777_0007, 2'd0, 2'd0);
		add_row(1'b0, OP_READ, 1'b1, 1'b0, 32'h0000_0100, 32'h0, 32'h4444_0004, 2'd1, 2'd0);

		cycle_limit = rows.size() * 200 + CACHE_LINES + 10;

		repeat (10) @(negedge clock);
		reset = 1'b0;

		i = 0;
		while (i < rows.size()) begin
			if (rows[i].concurrent && i + 1 < rows.size()) begin
				run_step(rows[i], 1'b1, rows[i + 1], 1'b1);
				i += 2;
			end else if (rows[i].io_port) begin
				run_step('0, 1'b0, rows[i], 1'b1);
				i++;
			end else begin
				run_step(rows[i], 1'b1, '0, 1'b0);
				i++;
			end
		end

		repeat (4) @(negedge clock);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut0.props0.assert_failures);
		if (errors == 0 && dut0.props0.assert_failures == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim/mem_subsys_props.sv ====
// Memory subsystem properties
// AXI valid hold, CPU ready pulse width and arbiter grant routing

`timescale 1ns/1ps

module mem_subsys_props (
	input logic i_clock,
	input logic i_reset,
	input bus_pkg::axil_aw_t i_aw,
	input logic i_awready,
	input bus_pkg::axil_w_t i_w,
	input logic i_wready,
	input bus_pkg::axil_ar_t i_ar,
	input logic i_arready,
	input logic i_cpu_ready,
	input logic i_busy,
	input logic i_owner,
	input bus_pkg::bus_req_t i_req0,
	input bus_pkg::bus_req_t i_req1,
	input bus_pkg::bus_req_t i_granted
);
	int assert_failures;

	initial assert_failures = 0;

	// ====================
	// AXI handshakes
	// ====================

	aw_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_aw.valid && !i_awready |=> i_aw.valid)
		else begin
			assert_failures++;
			$error("AW valid dropped before AW ready");
		end

	w_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_w.valid && !i_wready |=> i_w.valid)
		else begin
			assert_failures++;
			$error("W valid dropped before W ready");
		end

	ar_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ar.valid && !i_arready |=> i_ar.valid)
		else begin
			assert_failures++;
			$error("AR valid dropped before AR ready");
		end

	// Ready is a single-cycle pulse
	cpu_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_cpu_ready |=> !i_cpu_ready)
		else begin
			assert_failures++;
			$error("CPU ready high in two consecutive cycles");
		end

	// AXI address in flight belongs to the peer that owns the bus
	grant_owner: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_aw.valid || i_ar.valid) |-> i_busy && i_granted.valid
			&& (i_owner ? i_req1.valid : i_req0.valid)
			&& ((i_aw.valid ? i_aw.addr : i_ar.addr)
				== (i_owner ? i_req1.address : i_req0.address)))
		else begin
			assert_failures++;
			$error("Arbiter forwards a request that is not from the owner");
		end

endmodule

bind mem_subsys_top mem_subsys_props props0 (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_aw(o_aw),
	.i_awready(i_awready),
	.i_w(o_w),
	.i_wready(i_wready),
	.i_ar(o_ar),
	.i_arready(i_arready),
	.i_cpu_ready(o_cpu_ready),
	.i_busy(u_arbiter.busy),
	.i_owner(u_arbiter.owner),
	.i_req0(cache_req),
	.i_req1(io_req),
	.i_granted(axil_req)
);

// ==== sim/axil_mem_model.sv ====
// AXI4-Lite slave memory
// Word memory with random channel ready and response delays, one transaction at a time

`timescale 1ns/1ps

module axil_mem_model (
	input logic i_clock,
	input logic i_reset,
	input bus_pkg::axil_aw_t i_aw,
	output logic o_awready,
	input bus_pkg::axil_w_t i_w,
	output logic o_wready,
	output bus_pkg::axil_b_t o_b,
	input logic i_bready,
	input bus_pkg::axil_ar_t i_ar,
	output logic o_arready,
	output bus_pkg::axil_r_t o_r,
	input logic i_rready
);
	import bus_pkg::*;

	logic [31:0] mem [logic [31:0]];
	integer seed;
	int delay;
	logic have_aw;
	logic have_w;
	logic have_ar;
	logic [31:0] aw_addr;
	logic [31:0] w_data;
	logic [3:0] w_strb;
	logic [31:0] ar_addr;

	// Unwritten words read back a pattern of their own address
	function automatic logic [31:0] read_word(input logic [31:0] address);
		if (mem.exists(address))
			return mem[address];
		return address ^ 32'hc0de_0000;
	endfunction

	// Byte lanes outside the strobe keep their old value
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] word;
		word = old_word;
		for (int n = 0; n < 4; n++) begin
			if (strb[n])
				word[8*n +: 8] = new_word[8*n +: 8];
		end
		return word;
	endfunction

	initial seed = 32'hbc560520;

	always @(posedge i_clock) begin
		if (i_reset) begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_arready <= 1'b0;
			o_b <= '0;
			o_r <= '0;
			have_aw <= 1'b0;
			have_w <= 1'b0;
			have_ar <= 1'b0;
			delay <= 0;
		end else begin
			// Ready about three cycles in four
			o_awready <= ($random(seed) & 3) != 0;
			o_wready <= ($random(seed) & 3) != 0;
			o_arready <= ($random(seed) & 3) != 0;

			if (i_aw.valid && o_awready) begin
				have_aw <= 1'b1;
				aw_addr <= i_aw.addr;
			end
			if (i_w.valid && o_wready) begin
				have_w <= 1'b1;
				w_data <= i_w.data;
				w_strb <= i_w.strb;
			end
			if (i_ar.valid && o_arready) begin
				have_ar <= 1'b1;
				ar_addr <= i_ar.addr;
			end

			// ====================
			// Responses
			// ====================
			if (have_aw && have_w && !o_b.valid) begin
				if (delay == 0) begin
					mem[aw_addr] = merge_bytes(read_word(aw_addr), w_data, w_strb);
					o_b <= '{valid: 1'b1, resp: 2'b00};
					have_aw <= 1'b0;
					have_w <= 1'b0;
					delay <= $random(seed) & 3;
				end else begin
					delay <= delay - 1;
				end
			end
			if (o_b.valid && i_bready)
				o_b.valid <= 1'b0;

			if (have_ar && !o_r.valid) begin
				if (delay == 0) begin
					o_r <= '{valid: 1'b1, data: read_word(ar_addr), resp: 2'b00};
					have_ar <= 1'b0;
					delay <= $random(seed) & 3;
				end else begin
					delay <= delay - 1;
				end
			end
			if (o_r.valid && i_rready)
				o_r.valid <= 1'b0;
		end
	end

endmodule

// ==== design/mem_subsys_top.sv ====
// Memory subsystem top
// Data cache and I/O port sharing one AXI4-Lite master through a round-robin arbiter

`timescale 1ns/1ps

module mem_subsys_top (
	input logic i_clock,
	input logic i_reset,

	// CPU port
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input logic i_cpu_flush,
	input logic i_cpu_cacheable,
	input logic [31:0] i_cpu_address,
	input logic [31:0] i_cpu_wdata,
	output logic o_cpu_ready,
	output logic [31:0] o_cpu_rdata,

	// I/O port
	input logic i_io_request,
	input logic i_io_rw,
	input logic [31:0] i_io_address,
	input logic [31:0] i_io_wdata,
	output logic o_io_ready,
	output logic [31:0] o_io_rdata,

	// Statistics
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count,

	// AXI4-Lite
	output bus_pkg::axil_aw_t o_aw,
	input logic i_awready,
	output bus_pkg::axil_w_t o_w,
	input logic i_wready,
	input bus_pkg::axil_b_t i_b,
	output logic o_bready,
	output bus_pkg::axil_ar_t o_ar,
	input logic i_arready,
	input bus_pkg::axil_r_t i_r,
	output logic o_rready
);
	import bus_pkg::*;

	bus_req_t cache_req;
	bus_rsp_t cache_rsp;
	bus_req_t io_req;
	bus_rsp_t io_rsp;
	bus_req_t axil_req;
	bus_rsp_t axil_rsp;

	dcache_ctrl u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_flush(i_cpu_flush),
		.i_cpu_cacheable(i_cpu_cacheable),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_ready(o_cpu_ready),
		.o_cpu_rdata(o_cpu_rdata),
		.o_bus_req(cache_req),
		.i_bus_rsp(cache_rsp),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

	bus_wbuf u_io_wbuf (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rw(i_io_rw),
		.i_request(i_io_request),
		.i_address(i_io_address),
		.i_wdata(i_io_wdata),
		.o_ready(o_io_ready),
		.o_rdata(o_io_rdata),
		.o_bus_req(io_req),
		.i_bus_rsp(io_rsp)
	);

	// Cache is peer 0, I/O is peer 1
	bus_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req0(cache_req),
		.i_req1(io_req),
		.o_rsp0(cache_rsp),
		.o_rsp1(io_rsp),
		.o_req(axil_req),
		.i_rsp(axil_rsp)
	);

	axil_master u_axil (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(axil_req),
		.o_rsp(axil_rsp),
		.o_aw(o_aw),
		.i_awready(i_awready),
		.o_w(o_w),
		.i_wready(i_wready),
		.i_b(i_b),
		.o_bready(o_bready),
		.o_ar(o_ar),
		.i_arready(i_arready),
		.i_r(i_r),
		.o_rready(o_rready)
	);

endmodule

// ==== design/axil_master.sv ====
// AXI4-Lite master bridge
// Runs one shared bus request at a time as an AXI4-Lite read or write

`timescale 1ns/1ps

module axil_master (
	input logic i_clock,
	input logic i_reset,
	input bus_pkg::bus_req_t i_req,
	output bus_pkg::bus_rsp_t o_rsp,
	output bus_pkg::axil_aw_t o_aw,
	input logic i_awready,
	output bus_pkg::axil_w_t o_w,
	input logic i_wready,
	input bus_pkg::axil_b_t i_b,
	output logic o_bready,
	output bus_pkg::axil_ar_t o_ar,
	input logic i_arready,
	input bus_pkg::axil_r_t i_r,
	output logic o_rready
);
	typedef enum logic [2:0] {
		M_IDLE,
		M_WRITE,
		M_WAIT_B,
		M_READ,
		M_WAIT_R
	} m_state_t;

	m_state_t state;
	logic aw_pending;
	logic w_pending;
	logic aw_done;
	logic w_done;
	logic [31:0] addr_q;
	logic [31:0] data_q;

	// Channel accepted earlier or in this cycle
	assign aw_done = !aw_pending || i_awready;
	assign w_done = !w_pending || i_wready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= M_IDLE;
			aw_pending <= 1'b0;
			w_pending <= 1'b0;
		end else begin
			case (state)
				M_IDLE: begin
					if (i_req.valid) begin
						if (i_req.rw) begin
							aw_pending <= 1'b1;
							w_pending <= 1'b1;
							state <= M_WRITE;
						end else begin
							state <= M_READ;
						end
					end
				end
				// AW and W accepted independently
				M_WRITE: begin
					if (i_awready)
						aw_pending <= 1'b0;
					if (i_wready)
						w_pending <= 1'b0;
					if (aw_done && w_done)
						state <= M_WAIT_B;
				end
				M_WAIT_B: begin
					if (i_b.valid)
						state <= M_IDLE;
				end
				M_READ: begin
					if (i_arready)
						state <= M_WAIT_R;
				end
				M_WAIT_R: begin
					if (i_r.valid)
						state <= M_IDLE;
				end
				default: begin
					state <= M_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == M_IDLE && i_req.valid) begin
			addr_q <= i_req.address;
			data_q <= i_req.wdata;
		end
	end

	assign o_aw = '{valid: aw_pending, addr: addr_q, prot: 3'b000};
	assign o_w = '{valid: w_pending, data: data_q, strb: 4'hf};
	assign o_ar = '{valid: (state == M_READ), addr: addr_q, prot: 3'b000};
	assign o_bready = (state == M_WAIT_B);
	assign o_rready = (state == M_WAIT_R);

	// Completion in the cycle of the B or R handshake
	assign o_rsp = '{
		ready: (o_bready && i_b.valid) || (o_rready && i_r.valid),
		rdata: i_r.data
	};

endmodule

// ==== design/bus_arbiter.sv ====
// Shared bus arbiter
// Round-robin grant of the bus to one of two peers, held for a whole transaction

`timescale 1ns/1ps

module bus_arbiter (
	input logic i_clock,
	input logic i_reset,
	input bus_pkg::bus_req_t i_req0,
	input bus_pkg::bus_req_t i_req1,
	output bus_pkg::bus_rsp_t o_rsp0,
	output bus_pkg::bus_rsp_t o_rsp1,
	output bus_pkg::bus_req_t o_req,
	input bus_pkg::bus_rsp_t i_rsp
);
	logic busy;
	logic owner;
	logic last_grant;

	// Owner changes only while the bus is idle
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			owner <= 1'b0;
			// Peer 0 first after reset
			last_grant <= 1'b1;
		end else if (!busy) begin
			if (i_req0.valid && i_req1.valid) begin
				owner <= !last_grant;
				busy <= 1'b1;
			end else if (i_req0.valid) begin
				owner <= 1'b0;
				busy <= 1'b1;
			end else if (i_req1.valid) begin
				owner <= 1'b1;
				busy <= 1'b1;
			end
		end else if (i_rsp.ready) begin
			busy <= 1'b0;
			last_grant <= owner;
		end
	end

	always_comb begin
		o_req = '0;
		if (busy)
			o_req = owner ? i_req1 : i_req0;

		// Read data to both, completion only to the owner
		o_rsp0 = i_rsp;
		o_rsp0.ready = i_rsp.ready && busy && !owner;
		o_rsp1 = i_rsp;
		o_rsp1.ready = i_rsp.ready && busy && owner;
	end

endmodule

// ==== design/dcache_ctrl.sv ====
// Data cache controller
// Direct-mapped write-back cache with hot line check, refill, flush and reset sweep

`timescale 1ns/1ps

module dcache_ctrl (
	input logic i_clock,
	input logic i_reset,
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input logic i_cpu_flush,
	input logic i_cpu_cacheable,
	input logic [31:0] i_cpu_address,
	input logic [31:0] i_cpu_wdata,
	output logic o_cpu_ready,
	output logic [31:0] o_cpu_rdata,
	output bus_pkg::bus_req_t o_bus_req,
	input bus_pkg::bus_rsp_t i_bus_rsp,
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);
	import cache_pkg::*;

	typedef enum logic [3:0] {
		S_SWEEP,
		S_IDLE,
		S_LOOKUP,
		S_HIT,
		S_EVICT,
		S_REFILL,
		S_PASS,
		S_FLUSH_READ,
		S_FLUSH_CHECK,
		S_FLUSH_WB
	} state_t;

	state_t state;
	logic [INDEX_BITS-1:0] line;
	logic last_line;

	// Bus buffer request
	logic wb_request;
	logic wb_rw;
	logic [31:0] wb_address;
	logic [31:0] wb_wdata;
	logic wb_ready;
	logic [31:0] wb_rdata;

	// Line RAM port
	logic ram_we;
	logic [INDEX_BITS-1:0] ram_index;
	cache_entry_t ram_wentry;
	cache_entry_t rentry;
	cache_entry_t cpu_entry;
	logic tag_match;
	logic victim_dirty;

	bus_wbuf u_wbuf (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rw(wb_rw),
		.i_request(wb_request),
		.i_address(wb_address),
		.i_wdata(wb_wdata),
		.o_ready(wb_ready),
		.o_rdata(wb_rdata),
		.o_bus_req(o_bus_req),
		.i_bus_rsp(i_bus_rsp)
	);

	dcache_ram u_ram (
		.i_clock(i_clock),
		.i_we(ram_we),
		.i_index(ram_index),
		.i_wentry(ram_wentry),
		.o_rentry(rentry)
	);

	assign last_line = (line == INDEX_BITS'(CACHE_LINES - 1));
	// Full word address compare, so a stale entry of another index never hits
	assign tag_match = rentry.valid && (rentry.address == i_cpu_address[31:2]);
	assign victim_dirty = rentry.valid && rentry.dirty;
	assign cpu_entry = '{
		data: i_cpu_wdata,
		address: i_cpu_address[31:2],
		dirty: 1'b1,
		valid: 1'b1
	};

	// Sweep and flush walk the lines, all else follows the CPU address
	always_comb begin
		if (state == S_SWEEP || state == S_FLUSH_READ || state == S_FLUSH_CHECK
				|| state == S_FLUSH_WB)
			ram_index = line;
		else
			ram_index = i_cpu_address[INDEX_BITS+1:2];
	end

	// ====================
	// Line RAM writes
	// ====================

	always_comb begin
		ram_we = 1'b0;
		ram_wentry = cpu_entry;
		case (state)
			S_SWEEP: begin
				ram_we = 1'b1;
				ram_wentry = CLEAR_ENTRY;
			end
			S_HIT: ram_we = i_cpu_rw;
			// Write miss on a clean line stores at once
			S_LOOKUP: ram_we = i_cpu_rw && !tag_match && !victim_dirty;
			S_EVICT: ram_we = i_cpu_rw && wb_ready;
			S_REFILL: begin
				ram_we = wb_ready;
				ram_wentry = '{
					data: wb_rdata,
					address: i_cpu_address[31:2],
					dirty: 1'b0,
					valid: 1'b1
				};
			end
			// Written back line turns clean
			S_FLUSH_WB: begin
				ram_we = wb_ready;
				ram_wentry = rentry;
				ram_wentry.dirty = 1'b0;
			end
			default: begin
				ram_we = 1'b0;
			end
		endcase
	end

	// ====================
	// Control FSM
	// ====================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_SWEEP;
			line <= '0;
			o_cpu_ready <= 1'b0;
			wb_request <= 1'b0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			o_cpu_ready <= 1'b0;
			case (state)
				// Ends with line back at zero
				S_SWEEP: begin
					line <= line + 1'b1;
					if (last_line)
						state <= S_IDLE;
				end

				S_IDLE: begin
					// Request still high in the cycle after ready
					if (i_cpu_request && !o_cpu_ready) begin
						if (i_cpu_flush) begin
							line <= '0;
							state <= S_FLUSH_READ;
						end else if (i_cpu_cacheable) begin
							state <= tag_match ? S_HIT : S_LOOKUP;
						end else begin
							wb_request <= 1'b1;
							wb_rw <= i_cpu_rw;
							wb_address <= i_cpu_address;
							wb_wdata <= i_cpu_wdata;
							state <= S_PASS;
						end
					end
				end

				S_LOOKUP: begin
					if (tag_match) begin
						state <= S_HIT;
					end else begin
						o_miss_count <= o_miss_count + 1'b1;
						if (victim_dirty) begin
							wb_request <= 1'b1;
							wb_rw <= 1'b1;
							wb_address <= {rentry.address, 2'b00};
							wb_wdata <= rentry.data;
							state <= S_EVICT;
						end else if (i_cpu_rw) begin
							o_cpu_ready <= 1'b1;
							state <= S_IDLE;
						end else begin
							wb_request <= 1'b1;
							wb_rw <= 1'b0;
							wb_address <= i_cpu_address;
							state <= S_REFILL;
						end
					end
				end

				S_HIT: begin
					o_hit_count <= o_hit_count + 1'b1;
					o_cpu_rdata <= rentry.data;
					o_cpu_ready <= 1'b1;
					state <= S_IDLE;
				end

				// Victim write-back, a write miss completes here
				S_EVICT: begin
					if (wb_ready) begin
						wb_request <= 1'b0;
						if (i_cpu_rw) begin
							o_cpu_ready <= 1'b1;
							state <= S_IDLE;
						end else begin
							state <= S_REFILL;
						end
					end
				end

				S_REFILL: begin
					wb_request <= 1'b1;
					wb_rw <= 1'b0;
					wb_address <= i_cpu_address;
					if (wb_ready) begin
						wb_request <= 1'b0;
						o_cpu_rdata <= wb_rdata;
						o_cpu_ready <= 1'b1;
						state <= S_IDLE;
					end
				end

				S_PASS: begin
					if (wb_ready) begin
						wb_request <= 1'b0;
						o_cpu_rdata <= wb_rdata;
						o_cpu_ready <= 1'b1;
						state <= S_IDLE;
					end
				end

				// RAM read of the current flush line
				S_FLUSH_READ: begin
					state <= S_FLUSH_CHECK;
				end

				S_FLUSH_CHECK: begin
					if (victim_dirty) begin
						wb_request <= 1'b1;
						wb_rw <= 1'b1;
						wb_address <= {rentry.address, 2'b00};
						wb_wdata <= rentry.data;
						state <= S_FLUSH_WB;
					end else begin
						line <= line + 1'b1;
						o_cpu_ready <= last_line;
						state <= last_line ? S_IDLE : S_FLUSH_READ;
					end
				end

				S_FLUSH_WB: begin
					if (wb_ready) begin
						wb_request <= 1'b0;
						line <= line + 1'b1;
						o_cpu_ready <= last_line;
						state <= last_line ? S_IDLE : S_FLUSH_READ;
					end
				end

				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== design/bus_wbuf.sv ====
// Bus write buffer
// Holds one request and runs it to completion on the shared bus

`timescale 1ns/1ps

module bus_wbuf (
	input logic i_clock,
	input logic i_reset,
	input logic i_rw,
	input logic i_request,
	input logic [31:0] i_address,
	input logic [31:0] i_wdata,
	output logic o_ready,
	output logic [31:0] o_rdata,
	output bus_pkg::bus_req_t o_bus_req,
	input bus_pkg::bus_rsp_t i_bus_rsp
);
	typedef enum logic [1:0] {
		WB_IDLE,
		WB_BUSY,
		WB_DONE
	} wb_state_t;

	wb_state_t state;
	logic req_rw;
	logic [31:0] req_address;
	logic [31:0] req_wdata;

	assign o_bus_req = '{
		valid: (state == WB_BUSY),
		rw: req_rw,
		address: req_address,
		wdata: req_wdata
	};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= WB_IDLE;
			o_ready <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				WB_IDLE: begin
					if (i_request)
						state <= WB_BUSY;
				end
				WB_BUSY: begin
					if (i_bus_rsp.ready) begin
						o_ready <= 1'b1;
						state <= WB_DONE;
					end
				end
				// Held request already served, wait for it to drop
				WB_DONE: begin
					if (!i_request)
						state <= WB_IDLE;
				end
				default: begin
					state <= WB_IDLE;
				end
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge i_clock) begin
		if (state == WB_IDLE && i_request) begin
			req_rw <= i_rw;
			req_address <= i_address;
			req_wdata <= i_wdata;
		end
		if (state == WB_BUSY && i_bus_rsp.ready)
			o_rdata <= i_bus_rsp.rdata;
	end

endmodule

// ==== design/dcache_ram.sv ====
// Data cache line RAM
// Single-port block RAM of cache entries, read every cycle with one cycle latency

`timescale 1ns/1ps

module dcache_ram (
	input logic i_clock,
	input logic i_we,
	input logic [cache_pkg::INDEX_BITS-1:0] i_index,
	input cache_pkg::cache_entry_t i_wentry,
	output cache_pkg::cache_entry_t o_rentry
);
	import cache_pkg::*;

	cache_entry_t mem [CACHE_LINES];

	// Write-first, so a line rewritten this cycle reads back new
	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_index] <= i_wentry;
			o_rentry <= i_wentry;
		end else begin
			o_rentry <= mem[i_index];
		end
	end

endmodule

// ==== design/cache_pkg.sv ====
// Cache package
// Geometry of the direct-mapped data cache and the layout of one RAM entry
package cache_pkg;

	localparam int INDEX_BITS = 6;
	localparam int CACHE_LINES = 1 << INDEX_BITS;

	// One line, one word
	typedef struct packed {
		logic [31:0] data;
		// Word address, byte offset dropped
		logic [29:0] address;
		logic dirty;
		logic valid;
	} cache_entry_t;

	// Written to every line by the reset sweep
	localparam cache_entry_t CLEAR_ENTRY = '{
		data: 32'h0000_0000,
		address: 30'h0,
		dirty: 1'b0,
		valid: 1'b0
	};

endpackage

// ==== design/bus_pkg.sv ====
// Bus package
// Shared peer bus request and response words, and AXI4-Lite channel payloads
package bus_pkg;

	// ====================
	// Shared bus
	// ====================

	typedef struct packed {
		logic valid;
		// 1 = write
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Ready is a one-cycle completion pulse
	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	// ====================
	// AXI4-Lite
	// ====================

	typedef struct packed {
		logic valid;
		logic [31:0] addr;
		logic [2:0] prot;
	} axil_aw_t;

	typedef struct packed {
		logic valid;
		logic [31:0] data;
		logic [3:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic valid;
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic valid;
		logic [31:0] addr;
		logic [2:0] prot;
	} axil_ar_t;

	typedef struct packed {
		logic valid;
		logic [31:0] data;
		logic [1:0] resp;
	} axil_r_t;

endpackage
